//--- logic/keccak_pkg.sv
package keccak_pkg;

    // Output word geometry
    localparam int w            = 64;
    localparam int w_byte_size  = w / 8;
    // Bit position of the word field inside output_size
    localparam int w_bit_width  = 6;
    localparam int w_byte_width = 3;

    // Largest squeezed block, SHAKE128 rate in bits
    localparam int RATE_SHAKE128 = 1344;

    // Words in a full rate block per mode
    localparam int DEPTH_SHAKE128 = 21;
    localparam int DEPTH_SHAKE256 = 17;

    // Operation mode codes
    localparam logic [1:0] SHAKE128_MODE     = 2'b10;
    localparam logic [1:0] SHAKE256_MODE_VEC = 2'b11;

    // Datapath strobes from the dump controller
    typedef struct packed {
        logic buffer_we;
        logic shift_en;
        logic counter_load;
        logic counter_rst;
        logic bytes_reset;
        logic bytes_enable;
    } dump_ctrl_t;

    // One squeezed block plus its sizing information
    typedef struct packed {
        logic [RATE_SHAKE128-1:0] rate_block;
        // Requested output length in bits
        logic [31:0]              output_size;
        logic [1:0]               operation_mode;
        logic                     last_block;
    } dump_req_t;

endpackage

//--- logic/piso_buffer.sv
`timescale 1ns/10ps

module piso_buffer #(
    parameter int WORD_WIDTH = keccak_pkg::w,
    parameter int BUF_DEPTH  = keccak_pkg::RATE_SHAKE128 / keccak_pkg::w
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            write_enable,
    input  logic                            shift_enable,
    input  logic [WORD_WIDTH*BUF_DEPTH-1:0] data_in,
    output logic [WORD_WIDTH-1:0]           data_out
);

    // Word 0 sits at the output
    logic [BUF_DEPTH-1:0][WORD_WIDTH-1:0] words_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            words_q <= '0;
        end else if (write_enable) begin
            // Lowest word of the block lands in slot 0
            words_q <= data_in;
        end else if (shift_enable) begin
            // Move everything down one slot, zero fill at the top
            words_q <= {{WORD_WIDTH{1'b0}}, words_q[BUF_DEPTH-1:1]};
        end
    end

    assign data_out = words_q[0];

endmodule

//--- logic/dump_word_tracker.sv
`timescale 1ns/10ps

module dump_word_tracker #(
    parameter int CNT_WIDTH = 5
) (
    input  logic                               clk,

    // Word countdown
    input  logic                               counter_rst,
    input  logic                               count_en,
    input  logic                               load_max,
    input  logic [CNT_WIDTH-1:0]               max_count,

    // Tail byte register
    input  logic                               bytes_reset,
    input  logic                               bytes_enable,
    input  logic [keccak_pkg::w_byte_width-1:0] tail_bytes,

    output logic                               last_word,
    output logic [keccak_pkg::w_byte_size-1:0]  byte_mask
);

    import keccak_pkg::*;

    // Words still to be emitted, including the one on the output
    logic [CNT_WIDTH-1:0]    count_q;
    // Valid bytes in the final word, zero means the word is full
    logic [w_byte_width-1:0] tail_q;
    logic                    partial_tail;

    always_ff @(posedge clk) begin
        if (counter_rst) begin
            count_q <= '0;
        end else if (load_max) begin
            count_q <= max_count;
        end else if (count_en && (count_q != '0)) begin
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bytes_reset) begin
            tail_q <= '0;
        end else if (bytes_enable) begin
            tail_q <= tail_bytes;
        end
    end

    // One word left
    assign last_word = (count_q == CNT_WIDTH'(1));

    assign partial_tail = (tail_q != '0);

    // Lanes 0 to 7-n are past the requested length on the final word
    always_comb begin
        if (last_word && partial_tail) begin
            byte_mask = {w_byte_size{1'b1}} >> tail_q;
        end else begin
            byte_mask = '0;
        end
    end

endmodule

//--- logic/dump_datapath.sv
`timescale 1ns/10ps

module dump_datapath #(
    parameter int WORD_WIDTH = keccak_pkg::w,
    parameter int BUF_DEPTH  = keccak_pkg::RATE_SHAKE128 / keccak_pkg::w,
    parameter int CNT_WIDTH  = 5
) (
    input  logic                   clk,
    input  logic                   rst,
    input  keccak_pkg::dump_req_t  req,
    input  keccak_pkg::dump_ctrl_t ctrl,
    output logic                   last_word,
    output logic [WORD_WIDTH-1:0]  data_out
);

    import keccak_pkg::*;

    logic [CNT_WIDTH-1:0]    max_count;
    logic [CNT_WIDTH-1:0]    last_block_words;
    logic [w_byte_width-1:0] tail_bytes;
    logic [WORD_WIDTH-1:0]   buffer_word;
    logic [w_byte_size-1:0]  byte_mask;

    piso_buffer #(
        .WORD_WIDTH (WORD_WIDTH),
        .BUF_DEPTH  (BUF_DEPTH)
    ) u_piso_buffer (
        .clk          (clk),
        .rst          (rst),
        .write_enable (ctrl.buffer_we),
        .shift_enable (ctrl.shift_en),
        .data_in      (req.rate_block),
        .data_out     (buffer_word)
    );

    dump_word_tracker #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_dump_word_tracker (
        .clk          (clk),
        .counter_rst  (ctrl.counter_rst),
        .count_en     (ctrl.shift_en),
        .load_max     (ctrl.counter_load),
        .max_count    (max_count),
        .bytes_reset  (ctrl.bytes_reset),
        .bytes_enable (ctrl.bytes_enable),
        .tail_bytes   (tail_bytes),
        .last_word    (last_word),
        .byte_mask    (byte_mask)
    );

    // Byte field of the requested size
    // Partial final word only on a last block
    assign tail_bytes = req.last_block ? req.output_size[w_bit_width-1:3] : '0;

    // Whole words plus one for a partial tail
    assign last_block_words = CNT_WIDTH'(req.output_size[w_bit_width+5:w_bit_width])
                            + CNT_WIDTH'(tail_bytes != '0);

    always_comb begin
        if (req.last_block) begin
            max_count = last_block_words;
        end else begin
            case (req.operation_mode)
                SHAKE256_MODE_VEC: max_count = CNT_WIDTH'(DEPTH_SHAKE256);
                SHAKE128_MODE:     max_count = CNT_WIDTH'(DEPTH_SHAKE128);
                default:           max_count = CNT_WIDTH'(DEPTH_SHAKE128);
            endcase
        end
    end

    // Zero the lanes beyond the requested output
    always_comb begin
        for (int i = 0; i < w_byte_size; i++) begin
            data_out[i*8 +: 8] = byte_mask[i] ? 8'h00 : buffer_word[i*8 +: 8];
        end
    end

endmodule

//--- logic/dump_control.sv
`timescale 1ns/10ps

module dump_control (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   block_valid,
    input  logic                   last_block,
    input  logic                   words_nonzero,
    input  logic                   last_word,
    output keccak_pkg::dump_ctrl_t ctrl,
    output logic                   data_valid,
    output logic                   block_done,
    output logic                   idle
);

    import keccak_pkg::*;

    // ST_LOAD holds a block that carries no words at all
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SHIFT
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   accept;
    logic   empty_block;
    logic   finish;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Strobes outside idle are dropped
    assign accept      = (state_q == ST_IDLE) && block_valid;
    assign empty_block = last_block && !words_nonzero;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (block_valid) begin
                    state_d = empty_block ? ST_LOAD : ST_SHIFT;
                end
            end
            ST_LOAD: begin
                state_d = ST_IDLE;
            end
            ST_SHIFT: begin
                if (last_word) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // Block ends on the final word, or straight away when empty
    assign finish = ((state_q == ST_SHIFT) && last_word) || (state_q == ST_LOAD);

    always_comb begin
        ctrl              = '0;
        ctrl.buffer_we    = accept;
        ctrl.counter_load = accept;
        ctrl.bytes_enable = accept;
        ctrl.shift_en     = (state_q == ST_SHIFT);
        // Clear the tracker once the block is out
        ctrl.counter_rst  = rst || finish;
        ctrl.bytes_reset  = rst || finish;
    end

    assign data_valid = (state_q == ST_SHIFT);
    assign block_done = finish;
    assign idle       = (state_q == ST_IDLE);

endmodule

//--- logic/squeeze_dump_top.sv
`timescale 1ns/10ps

module squeeze_dump_top #(
    parameter int WORD_WIDTH = keccak_pkg::w,
    parameter int BUF_DEPTH  = keccak_pkg::RATE_SHAKE128 / keccak_pkg::w,
    parameter int CNT_WIDTH  = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  block_valid,
    input  keccak_pkg::dump_req_t req,
    output logic [WORD_WIDTH-1:0] data_out,
    output logic                  data_valid,
    output logic                  block_done,
    output logic                  idle
);

    import keccak_pkg::*;

    dump_ctrl_t ctrl;
    logic       last_word;
    logic       words_nonzero;

    // Word or byte field set means at least one word to send
    assign words_nonzero = (req.output_size[w_bit_width+5:3] != '0);

    dump_control u_dump_control (
        .clk           (clk),
        .rst           (rst),
        .block_valid   (block_valid),
        .last_block    (req.last_block),
        .words_nonzero (words_nonzero),
        .last_word     (last_word),
        .ctrl          (ctrl),
        .data_valid    (data_valid),
        .block_done    (block_done),
        .idle          (idle)
    );

    dump_datapath #(
        .WORD_WIDTH (WORD_WIDTH),
        .BUF_DEPTH  (BUF_DEPTH),
        .CNT_WIDTH  (CNT_WIDTH)
    ) u_dump_datapath (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .ctrl      (ctrl),
        .last_word (last_word),
        .data_out  (data_out)
    );

endmodule

//--- dv/squeeze_dump_chk.sv
`timescale 1ns/10ps

module squeeze_dump_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   block_valid,
    input keccak_pkg::dump_req_t  req,
    input logic                   words_nonzero,
    input keccak_pkg::dump_ctrl_t ctrl,
    input logic                   data_valid,
    input logic                   block_done,
    input logic                   idle
);

    // Read by the testbench at the end of the run
    int unsigned failures = 0;

    logic empty_accept;

    // Accepted last block that carries no words
    assign empty_accept = idle && block_valid && req.last_block && !words_nonzero;

    // Done falls on the final word, except for an empty last block
    done_with_word: assert property (@(posedge clk) disable iff (rst)
        block_done |-> data_valid || $past(empty_accept))
    else begin
        $error("block_done raised without a data word");
        failures++;
    end

    empty_block_done: assert property (@(posedge clk) disable iff (rst)
        empty_accept |=> block_done && !data_valid)
    else begin
        $error("empty last block did not finish in the next cycle");
        failures++;
    end

    idle_not_busy: assert property (@(posedge clk) disable iff (rst)
        !(idle && data_valid))
    else begin
        $error("idle and data_valid high together");
        failures++;
    end

    ctrl_quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (ctrl == '0))
    else begin
        $error("datapath strobes active right after reset");
        failures++;
    end

endmodule

bind squeeze_dump_top squeeze_dump_chk u_squeeze_dump_chk (
    .clk           (clk),
    .rst           (rst),
    .block_valid   (block_valid),
    .req           (req),
    .words_nonzero (words_nonzero),
    .ctrl          (ctrl),
    .data_valid    (data_valid),
    .block_done    (block_done),
    .idle          (idle)
);

//--- dv/squeeze_dump_tb.sv
`timescale 1ns/10ps

module squeeze_dump_tb;

    import keccak_pkg::*;

    localparam int NUM_ROWS     = 10;
    localparam int WAIT_LIMIT   = 64;
    localparam int BLOCK_CHUNKS = RATE_SHAKE128 / 32;

    // Stimulus row with the expected word count
    typedef struct packed {
        logic [1:0]  mode;
        logic        last_block;
        logic [31:0] output_size;
        logic [5:0]  num_words;
        logic        busy_pulse;
    } row_t;

    logic         clk;
    logic         rst;
    logic         block_valid;
    dump_req_t    req;
    logic [w-1:0] data_out;
    logic         data_valid;
    logic         block_done;
    logic         idle;

    row_t stim_table [NUM_ROWS];
    int   checks_run;
    int   value_errors;

    squeeze_dump_top dut (
        .clk         (clk),
        .rst         (rst),
        .block_valid (block_valid),
        .req         (req),
        .data_out    (data_out),
        .data_valid  (data_valid),
        .block_done  (block_done),
        .idle        (idle)
    );

    always begin
        #10 clk = ~clk;
    end

    function automatic logic [RATE_SHAKE128-1:0] random_block();
        logic [RATE_SHAKE128-1:0] blk;
        for (int k = 0; k < BLOCK_CHUNKS; k++) begin
            blk[k*32 +: 32] = $urandom;
        end
        return blk;
    endfunction

    // Word idx of the block, lanes 0 to 7-n cleared on a partial final word
    function automatic logic [w-1:0] expected_word(
        input logic [RATE_SHAKE128-1:0] blk,
        input int                       idx,
        input row_t                     row
    );
        logic [w-1:0] word;
        logic [2:0]   tail;
        word = blk[idx*w +: w];
        tail = row.output_size[w_bit_width-1:3];
        if (row.last_block && (tail != 0) && (idx == int'(row.num_words) - 1)) begin
            for (int lane = 0; lane <= 7 - int'(tail); lane++) begin
                word[lane*8 +: 8] = 8'h00;
            end
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [w-1:0] got,
                               input logic [w-1:0] expected);
        checks_run++;
        assert (got === expected) else begin
            $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
            value_errors++;
        end
    endtask

    task automatic print_counts();
        $display("Checks run: %0d, value errors: %0d, assertion failures: %0d",
                 checks_run, value_errors, dut.u_squeeze_dump_chk.failures);
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        print_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic wait_for_idle();
        int cycles;
        cycles = 0;
        while (!idle && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!idle) begin
            stop_on_timeout("return to idle");
        end
    endtask

    task automatic apply_row(input int r);
        row_t                     row;
        logic [RATE_SHAKE128-1:0] blk;
        int                       cycles;
        int                       words;
        int                       done_cycle;
        logic                     done_seen;
        row        = stim_table[r];
        blk        = random_block();
        done_cycle = (row.num_words == 0) ? 1 : int'(row.num_words);
        wait_for_idle();
        req.rate_block     = blk;
        req.output_size    = row.output_size;
        req.operation_mode = row.mode;
        req.last_block     = row.last_block;
        block_valid        = 1'b1;
        cycles    = 0;
        words     = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            check_value("data_valid", w'(data_valid), w'(cycles <= int'(row.num_words)));
            check_value("block_done", w'(block_done), w'(cycles == done_cycle));
            if (data_valid && words < int'(row.num_words)) begin
                check_value("data_out", data_out, expected_word(blk, words, row));
                words++;
            end
            done_seen = block_done;
            // Strobe in the middle of a block, with a different size and payload
            if (row.busy_pulse && cycles == 3) begin
                block_valid     = 1'b1;
                req.rate_block  = random_block();
                req.output_size = 32'd64;
            end else begin
                block_valid = 1'b0;
            end
        end
        if (!done_seen) begin
            stop_on_timeout("block_done");
        end
        check_value("words received", w'(words), w'(row.num_words));
        @(negedge clk);
        check_value("idle", w'(idle), w'(1'b1));
        check_value("data_valid", w'(data_valid), w'(1'b0));
    endtask

    initial begin
        void'($urandom(5));
        checks_run   = 0;
        value_errors = 0;
        clk          = 1'b0;
        rst          = 1'b1;
        block_valid  = 1'b0;
        req          = '0;

        // mode, last_block, output_size, expected words, busy strobe
        stim_table[0] = '{SHAKE128_MODE,     1'b0, 32'd0,    6'd21, 1'b0};
        stim_table[1] = '{SHAKE256_MODE_VEC, 1'b0, 32'd200,  6'd17, 1'b0};
        stim_table[2] = '{SHAKE128_MODE,     1'b1, 32'd256,  6'd4,  1'b0};
        stim_table[3] = '{SHAKE256_MODE_VEC, 1'b1, 32'd1088, 6'd17, 1'b0};
        stim_table[4] = '{SHAKE128_MODE,     1'b1, 32'd344,  6'd6,  1'b0};
        stim_table[5] = '{SHAKE256_MODE_VEC, 1'b1, 32'd184,  6'd3,  1'b0};
        stim_table[6] = '{SHAKE256_MODE_VEC, 1'b1, 32'd8,    6'd1,  1'b0};
        stim_table[7] = '{SHAKE128_MODE,     1'b1, 32'd0,    6'd0,  1'b0};
        stim_table[8] = '{SHAKE128_MODE,     1'b1, 32'd1320, 6'd21, 1'b0};
        stim_table[9] = '{SHAKE128_MODE,     1'b0, 32'd0,    6'd21, 1'b1};

        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("idle", w'(idle), w'(1'b1));
        check_value("data_valid", w'(data_valid), w'(1'b0));
        check_value("block_done", w'(block_done), w'(1'b0));

        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end

        print_counts();
        if (value_errors == 0 && dut.u_squeeze_dump_chk.failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
logic/keccak_pkg.sv
logic/piso_buffer.sv
logic/dump_word_tracker.sv
logic/dump_datapath.sv
logic/dump_control.sv
logic/squeeze_dump_top.sv
dv/squeeze_dump_chk.sv
dv/squeeze_dump_tb.sv

//--- Bender.yml
package:
  name: squeeze_dump

sources:
  # Package first, then the design bottom up
  - files:
      - logic/keccak_pkg.sv
      - logic/piso_buffer.sv
      - logic/dump_word_tracker.sv
      - logic/dump_datapath.sv
      - logic/dump_control.sv
      - logic/squeeze_dump_top.sv

  # Simulation only
  - target: test
    files:
      - dv/squeeze_dump_chk.sv
      - dv/squeeze_dump_tb.sv
